//--- source/mem_bus_defines.svh
/*
 * Bus widths and address map of the CPU memory wrapper
 * Region is picked by the top address nibble; offset must fall below the span
 */
`ifndef MEM_BUS_DEFINES_SVH
`define MEM_BUS_DEFINES_SVH

`define MEM_ADDR_W     32
`define MEM_DATA_W     32
`define MEM_STRB_W     4

`define SRAM_BASE      32'h0000_0000   // 4 KiB of SRAM
`define SRAM_WORDS     1024
`define IRQ_BASE       32'h1000_0000   // Pending at +0, enable at +4
`define IRQ_SPAN       8

`define BUS_ERR_DATA   32'hBAD0_ADD5   // Read data on unmapped access
`define IRQ_EDGE_MASK  32'hFFFF_0000   // Inputs 16..31 latch on rising edge

`endif

//--- source/mem_bus_pkg.sv
/*
 * Packed words of the CPU memory bus
 * Field order of mem_fwd_t must stay wdata, wstrb, valid, addr from the top bit
 */
`include "mem_bus_defines.svh"

package mem_bus_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_DATA_W-1:0] data_t;
    typedef logic [`MEM_STRB_W-1:0] strb_t;

    // CPU > decoder, 69 bits
    typedef struct packed {
        data_t wdata;
        strb_t wstrb;   // Zero means read
        logic  valid;
        addr_t addr;
    } mem_fwd_t;

    // CPU < decoder, 33 bits
    typedef struct packed {
        data_t rdata;
        logic  ready;   // One-cycle pulse
    } mem_ret_t;

    typedef enum logic [1:0] {SEL_SRAM, SEL_IRQ, SEL_NONE} slave_sel_t;

endpackage

//--- source/mem_bus_pack.sv
/*
 * Packing boundary between the CPU bus and the decoder
 * Purely combinational, no clock
 */
module mem_bus_pack
    import mem_bus_pkg::*;
(
    // Loose CPU side
    input  logic     mem_valid,
    input  addr_t    mem_addr,
    input  data_t    mem_wdata,
    input  strb_t    mem_wstrb,
    output data_t    mem_rdata,
    output logic     mem_ready,
    // Packed decoder side
    output mem_fwd_t fwd,
    input  mem_ret_t ret
);

    // --------------------------------------------------
    //  Forward word
    // --------------------------------------------------
    assign fwd.wdata = mem_wdata;
    assign fwd.wstrb = mem_wstrb;
    assign fwd.valid = mem_valid;
    assign fwd.addr  = mem_addr;

    // --------------------------------------------------
    //  Return word
    // --------------------------------------------------
    assign mem_rdata = ret.rdata;   // Only meaningful with ready
    assign mem_ready = ret.ready;

endmodule

//--- source/bus_slice.sv
/*
 * One register stage for any packed bus word
 * Resets to all zero, so valid and ready come up inactive
 */
module bus_slice
    import mem_bus_pkg::*;
#(
    parameter type payload_t = mem_fwd_t
) (
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t d,
    output payload_t q
);

    // Whole word goes through, handshake bits included
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

//--- source/mem_bus_decoder.sv
/*
 * Address decoder, one request in flight at a time
 * ret_ready is the result stage ready ahead of the return slice, so blank covers the stale valid
 */
`include "mem_bus_defines.svh"

module mem_bus_decoder
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  mem_fwd_t   fwd,
    input  logic       ret_ready,
    output slave_sel_t sel,
    output logic       sram_req,
    output logic       irq_req,
    output logic       none_req,
    output addr_t      addr,
    output data_t      wdata,
    output strb_t      wstrb
);

    localparam int OFS_W = `MEM_ADDR_W - 4;
    localparam addr_t SRAM_BASE_A = `SRAM_BASE;
    localparam addr_t IRQ_BASE_A  = `IRQ_BASE;
    localparam logic [OFS_W-1:0] SRAM_SPAN = OFS_W'(`SRAM_WORDS * 4);
    localparam logic [OFS_W-1:0] IRQ_SPAN  = OFS_W'(`IRQ_SPAN);

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_BLANK} state_t;

    state_t     state;
    slave_sel_t region;
    logic       accept;

    // --------------------------------------------------
    //  Region decode
    // --------------------------------------------------
    always_comb begin
        region = SEL_NONE;
        if (fwd.addr[`MEM_ADDR_W-1 -: 4] == SRAM_BASE_A[`MEM_ADDR_W-1 -: 4] &&
            fwd.addr[OFS_W-1:0] < SRAM_SPAN) begin
            region = SEL_SRAM;
        end else if (fwd.addr[`MEM_ADDR_W-1 -: 4] == IRQ_BASE_A[`MEM_ADDR_W-1 -: 4] &&
                     fwd.addr[OFS_W-1:0] < IRQ_SPAN) begin
            region = SEL_IRQ;
        end
    end

    assign accept = (state == ST_IDLE) && fwd.valid;

    // --------------------------------------------------
    //  FSM and strobes
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            sel      <= SEL_NONE;
            sram_req <= 1'b0;
            irq_req  <= 1'b0;
            none_req <= 1'b0;
        end else begin
            sram_req <= 1'b0;   // Strobes last one cycle
            irq_req  <= 1'b0;
            none_req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        sel      <= region;   // Held until next accept
                        sram_req <= (region == SEL_SRAM);
                        irq_req  <= (region == SEL_IRQ);
                        none_req <= (region == SEL_NONE);
                        state    <= ST_WAIT;
                    end
                end
                ST_WAIT:  if (ret_ready) state <= ST_BLANK;
                ST_BLANK: state <= ST_IDLE;   // Slice still shows the old valid here
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Request fields, captured at accept
    always_ff @(posedge clk) begin
        if (accept) begin
            addr  <= fwd.addr;
            wdata <= fwd.wdata;
            wstrb <= fwd.wstrb;
        end
    end

    // Exactly one target per accept, never a strobe without one
    a_one_req: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({sram_req, irq_req, none_req}) &&
        ((sram_req || irq_req || none_req) -> $past(accept)))
        else $error("decoder strobe outside accept or not one-hot");

endmodule

//--- source/mem_bus_return.sv
/*
 * Result stage, merges slave returns into one word
 * bus_err is sticky until reset
 */
`include "mem_bus_defines.svh"

module mem_bus_return
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  slave_sel_t sel,          // Latched by the decoder at accept
    input  logic       none_req,
    input  data_t      sram_rdata,
    input  logic       sram_ack,
    input  data_t      irq_rdata,
    input  logic       irq_ack,
    output mem_ret_t   ret,
    output logic       bus_err
);

    logic none_d;   // Unmapped answer, lines up with a slave ack

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            none_d  <= 1'b0;
            bus_err <= 1'b0;
        end else begin
            none_d <= none_req;
            if (none_req) bus_err <= 1'b1;
        end
    end

    // --------------------------------------------------
    //  Return mux
    // --------------------------------------------------
    always_comb begin
        case (sel)
            SEL_SRAM: ret = '{rdata: sram_rdata, ready: sram_ack};
            SEL_IRQ:  ret = '{rdata: irq_rdata, ready: irq_ack};
            default:  ret = '{rdata: `BUS_ERR_DATA, ready: none_d};
        endcase
    end

    // A stray ack would be swallowed by the mux
    a_ack_sel: assert property (@(posedge clk) disable iff (!arst_n)
        (sram_ack -> sel == SEL_SRAM) && (irq_ack -> sel == SEL_IRQ))
        else $error("ack from a slave that was not selected");

endmodule

//--- source/sram_slave.sv
/*
 * Word-addressed SRAM with byte strobes, answers one cycle after req
 * Contents are undefined after reset; addr bits 1:0 are ignored
 */
`include "mem_bus_defines.svh"

module sram_slave
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  req,
    input  addr_t addr,
    input  data_t wdata,
    input  strb_t wstrb,
    output data_t rdata,
    output logic  ack
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    data_t            mem [`SRAM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = addr[IDX_W+1:2];   // Byte address to word index

    // --------------------------------------------------
    //  Array, read-before-write
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (req) begin
            rdata <= mem[idx];   // Old word, also on a write
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (wstrb[b]) mem[idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // One answer per request, and the decoder never strobes twice in a row
    a_ack_next: assert property (@(posedge clk) disable iff (!arst_n)
        req |=> (ack && !req))
        else $error("SRAM ack did not follow req by one cycle");

endmodule

//--- source/irq_ctrl_slave.sv
/*
 * Interrupt controller, pending at offset 0 and enable at offset 4
 * Edge bits need a low sample before a rise counts; other bits read as level
 */
`include "mem_bus_defines.svh"

module irq_ctrl_slave
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  data_t irq_flags,
    input  logic  req,
    input  addr_t addr,
    input  data_t wdata,
    input  strb_t wstrb,
    output data_t rdata,
    output logic  ack,
    output logic  irq
);

    localparam data_t EDGE_MASK = `IRQ_EDGE_MASK;

    data_t flags_prev;
    data_t pending;
    data_t enable;
    data_t byte_mask;   // wstrb widened to bits
    data_t rising;
    data_t clr;
    data_t status;
    logic  wr_pend;
    logic  wr_en;

    // --------------------------------------------------
    //  Decode and edge detect
    // --------------------------------------------------
    always_comb begin
        for (int b = 0; b < `MEM_STRB_W; b++) begin
            byte_mask[8*b +: 8] = {8{wstrb[b]}};
        end
    end

    assign wr_pend = req && !addr[2] && (|wstrb);
    assign wr_en   = req &&  addr[2] && (|wstrb);
    assign rising  = irq_flags & ~flags_prev & EDGE_MASK;
    assign clr     = wr_pend ? (wdata & byte_mask) : '0;   // Write one to clear
    assign status  = (pending & EDGE_MASK) | (irq_flags & ~EDGE_MASK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_prev <= '0;
            pending    <= '0;
            enable     <= '0;
            ack        <= 1'b0;
        end else begin
            flags_prev <= irq_flags;
            pending    <= (pending & ~clr) | rising;   // New edge beats a clear
            if (wr_en) enable <= (enable & ~byte_mask) | (wdata & byte_mask);
            ack        <= req;
        end
    end

    // Read data sampled before this cycle's update
    always_ff @(posedge clk) begin
        if (req) rdata <= addr[2] ? enable : status;
    end

    assign irq = |(pending & enable);

endmodule

//--- source/mem_bus_top.sv
/*
 * Memory side of the CPU, SRAM plus interrupt controller
 * mem_ready comes 4 cycles after mem_valid is first sampled; hold request until then
 */
module mem_bus_top
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  mem_valid,
    input  addr_t mem_addr,
    input  data_t mem_wdata,
    input  strb_t mem_wstrb,
    output data_t mem_rdata,
    output logic  mem_ready,
    input  data_t irq_flags,
    output logic  irq,
    output logic  bus_err
);

    mem_fwd_t   fwd_d, fwd_q;
    mem_ret_t   ret_d, ret_q;
    slave_sel_t sel;
    logic       sram_req, irq_req, none_req;
    logic       sram_ack, irq_ack;
    addr_t      req_addr;
    data_t      req_wdata, sram_rdata, irq_rdata;
    strb_t      req_wstrb;

    mem_bus_pack pack_i (
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .mem_ready(mem_ready),
        .fwd(fwd_d), .ret(ret_q)
    );

    // --------------------------------------------------
    //  Slices, one per direction
    // --------------------------------------------------
    bus_slice #(.payload_t(mem_fwd_t)) fwd_slice_i (
        .clk(clk), .arst_n(arst_n), .d(fwd_d), .q(fwd_q)
    );
    bus_slice #(.payload_t(mem_ret_t)) ret_slice_i (
        .clk(clk), .arst_n(arst_n), .d(ret_d), .q(ret_q)
    );

    // Decoder leaves wait on the result stage ready, ahead of the slice
    mem_bus_decoder decoder_i (
        .clk(clk), .arst_n(arst_n), .fwd(fwd_q), .ret_ready(ret_d.ready), .sel(sel),
        .sram_req(sram_req), .irq_req(irq_req), .none_req(none_req),
        .addr(req_addr), .wdata(req_wdata), .wstrb(req_wstrb)
    );

    sram_slave sram_i (
        .clk(clk), .arst_n(arst_n), .req(sram_req), .addr(req_addr),
        .wdata(req_wdata), .wstrb(req_wstrb), .rdata(sram_rdata), .ack(sram_ack)
    );

    irq_ctrl_slave irq_ctrl_i (
        .clk(clk), .arst_n(arst_n), .irq_flags(irq_flags), .req(irq_req),
        .addr(req_addr), .wdata(req_wdata), .wstrb(req_wstrb),
        .rdata(irq_rdata), .ack(irq_ack), .irq(irq)
    );

    mem_bus_return return_i (
        .clk(clk), .arst_n(arst_n), .sel(sel), .none_req(none_req),
        .sram_rdata(sram_rdata), .sram_ack(sram_ack),
        .irq_rdata(irq_rdata), .irq_ack(irq_ack),
        .ret(ret_d), .bus_err(bus_err)
    );

endmodule

//--- verification/mem_bus_tb.sv
/*
 * Testbench for mem_bus_top, plays the CPU against a reference model
 * irq_flags change only between accesses; SRAM bytes never written are not compared
 */
`include "mem_bus_defines.svh"

module mem_bus_tb
    import mem_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    TIMEOUT_CYC = 20;
    localparam int    LATENCY     = 4;   // Drive edge to mem_ready, chained or not
    localparam data_t EDGE_MASK   = `IRQ_EDGE_MASK;
    localparam addr_t IRQ_PEND    = `IRQ_BASE;
    localparam addr_t IRQ_EN      = `IRQ_BASE + 4;

    logic  clk = 1'b0;
    logic  arst_n;
    logic  mem_valid;
    addr_t mem_addr;
    data_t mem_wdata;
    strb_t mem_wstrb;
    data_t mem_rdata;
    logic  mem_ready;
    data_t irq_flags;
    logic  irq;
    logic  bus_err;

    integer seed     = 18910;
    int     errors   = 0;
    int     accesses = 0;

    // --------------------------------------------------
    //  Reference model
    // --------------------------------------------------
    data_t ram_model [`SRAM_WORDS];
    strb_t ram_known [`SRAM_WORDS];   // Bytes written at least once
    int    written [$];
    data_t pend_model;
    data_t en_model;
    logic  err_model;

    mem_bus_top dut_i (
        .clk(clk), .arst_n(arst_n), .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata),
        .mem_ready(mem_ready), .irq_flags(irq_flags), .irq(irq), .bus_err(bus_err)
    );

    always #5 clk = ~clk;

    function automatic data_t lane_mask(input strb_t s);
        data_t m;
        for (int b = 0; b < `MEM_STRB_W; b++) begin
            m[8*b +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    task automatic report_error(input string what, input data_t got, input data_t exp);
        errors++;
        $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    // One request, held until mem_ready; called at posedge + 1
    task automatic bus_access(input addr_t a, input data_t wd, input strb_t ws,
                              output data_t rd);
        int cyc;
        bit seen;
        cyc       = 0;
        seen      = 1'b0;
        mem_valid = 1'b1;
        mem_addr  = a;
        mem_wdata = wd;
        mem_wstrb = ws;
        while (!seen && cyc < TIMEOUT_CYC) begin
            @(posedge clk);
            #1;
            cyc++;
            seen = (mem_ready === 1'b1);
        end
        if (!seen) begin
            $display("Timeout: the DUT never answered the access to address %h", a);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            rd = mem_rdata;
            accesses++;
            if (cyc != LATENCY) begin
                errors++;
                $display("Error at %0d ns: mem_ready after %0d cycles, expected %0d",
                         $time, cyc, LATENCY);
            end
        end
    endtask

    // Valid low; ready must stay low, so a pulse is one cycle
    task automatic idle_cycles(input int n);
        mem_valid = 1'b0;
        mem_wstrb = '0;
        repeat (n) begin
            @(posedge clk);
            #1;
            if (mem_ready !== 1'b0) report_error("mem_ready while idle", data_t'(mem_ready), '0);
        end
    endtask

    task automatic check_side();
        if (irq !== (|(pend_model & en_model)))
            report_error("irq", data_t'(irq), data_t'(|(pend_model & en_model)));
        if (bus_err !== err_model) report_error("bus_err", data_t'(bus_err), data_t'(err_model));
    endtask

    task automatic sram_write(input int idx, input data_t wd, input strb_t ws);
        data_t rd;
        bus_access(addr_t'(idx * 4), wd, ws, rd);
        ram_model[idx] = (ram_model[idx] & ~lane_mask(ws)) | (wd & lane_mask(ws));
        ram_known[idx] |= ws;
        written.push_back(idx);
        check_side();
    endtask

    task automatic sram_read(input int idx);
        data_t rd;
        data_t km;
        bus_access(addr_t'(idx * 4), '0, '0, rd);
        km = lane_mask(ram_known[idx]);   // Compare known bytes only
        if ((rd & km) !== (ram_model[idx] & km))
            report_error($sformatf("SRAM word %0d", idx), rd & km, ram_model[idx] & km);
        check_side();
    endtask

    task automatic irq_write(input bit to_en, input data_t wd, input strb_t ws);
        data_t rd;
        data_t m;
        m = lane_mask(ws);
        bus_access(to_en ? IRQ_EN : IRQ_PEND, wd, ws, rd);
        if (to_en) en_model = (en_model & ~m) | (wd & m);
        else pend_model = pend_model & ~(wd & m);   // Write one to clear
        check_side();
    endtask

    task automatic irq_read(input bit to_en);
        data_t rd;
        data_t exp;
        exp = to_en ? en_model : ((pend_model & EDGE_MASK) | (irq_flags & ~EDGE_MASK));
        bus_access(to_en ? IRQ_EN : IRQ_PEND, '0, '0, rd);
        if (rd !== exp) report_error(to_en ? "IRQ enable" : "IRQ status", rd, exp);
        check_side();
    endtask

    task automatic unmapped(input addr_t a, input data_t wd, input strb_t ws);
        data_t rd;
        bus_access(a, wd, ws, rd);
        err_model = 1'b1;   // Sticky
        if (rd !== `BUS_ERR_DATA) report_error("unmapped read data", rd, `BUS_ERR_DATA);
        check_side();
    endtask

    // New level, two cycles so the edge is latched
    task automatic set_flags(input data_t fl);
        pend_model = pend_model | (fl & ~irq_flags & EDGE_MASK);
        irq_flags  = fl;
        idle_cycles(2);
    endtask

    initial begin
        data_t wd;
        int    idx;
        arst_n    = 1'b0;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        irq_flags = '0;
        for (int i = 0; i < `SRAM_WORDS; i++) begin
            ram_model[i] = '0;
            ram_known[i] = '0;
        end
        pend_model = '0;
        en_model   = '0;
        err_model  = 1'b0;
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
        idle_cycles(2);

        // --------------------------------------------------
        //  SRAM, random writes then reads
        // --------------------------------------------------
        repeat (60) begin
            idx = {$random(seed)} % 128;   // Small window, many merges
            sram_write(idx, $random(seed), strb_t'({$random(seed)} % 15 + 1));
            idle_cycles({$random(seed)} % 3 + 1);
        end
        repeat (60) begin
            sram_read(written[{$random(seed)} % written.size()]);
            idle_cycles(1);
        end

        // --------------------------------------------------
        //  IRQ edges, levels, clear and enable
        // --------------------------------------------------
        repeat (20) begin
            set_flags($random(seed));
            irq_read(1'b0);
            set_flags(irq_flags & ~EDGE_MASK);   // Fall, pending must hold
            irq_read(1'b0);
            idle_cycles(1);
        end
        irq_write(1'b1, $random(seed), 4'hF);
        idle_cycles(1);
        repeat (12) begin
            irq_write(1'b1, $random(seed), strb_t'({$random(seed)} % 15 + 1));
            idle_cycles(1);
            irq_read(1'b1);
            idle_cycles(1);
            irq_write(1'b0, $random(seed), strb_t'({$random(seed)} % 15 + 1));
            idle_cycles(1);
            irq_read(1'b0);
            set_flags($random(seed));   // Re-arm some pending bits
        end

        // --------------------------------------------------
        //  Unmapped accesses, SRAM must stay intact
        // --------------------------------------------------
        unmapped(32'h2000_0000 | ($random(seed) & 32'h0FFF_FFFC), '0, '0);
        idle_cycles(1);
        unmapped(32'h0000_1000 | ($random(seed) & 32'h0000_01FC), $random(seed), 4'hF);
        idle_cycles(1);
        unmapped(32'h1000_0008, $random(seed), 4'hF);   // Just past the IRQ block
        idle_cycles(1);
        for (int i = 0; i < written.size(); i++) begin
            sram_read(written[i]);
            idle_cycles(1);
        end

        // --------------------------------------------------
        //  Back-to-back, held across the blank cycle
        // --------------------------------------------------
        wd = $random(seed);
        sram_write(200, wd, 4'hF);
        sram_write(200, ~wd, 4'h1);   // A replayed first write would undo byte 0
        sram_read(200);
        sram_write(201, $random(seed), 4'hF);
        unmapped(32'h3000_0000, '0, '0);
        irq_read(1'b1);
        sram_read(201);
        idle_cycles(1);
        repeat (24) begin
            idx = 200 + {$random(seed)} % 8;
            if ({$random(seed)} % 2 == 0) sram_write(idx, $random(seed), 4'hF);
            else sram_read(idx);
        end
        idle_cycles(1);
        for (int i = 200; i < 208; i++) begin
            sram_read(i);
            idle_cycles(1);
        end

        idle_cycles(2);
        $display("Accesses: %0d, errors: %0d", accesses, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/mem_bus_pkg.sv
source/mem_bus_pack.sv
source/bus_slice.sv
source/mem_bus_decoder.sv
source/mem_bus_return.sv
source/sram_slave.sv
source/irq_ctrl_slave.sv
source/mem_bus_top.sv
verification/mem_bus_tb.sv

//--- Makefile
# Verilator build and run of the memory bus testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for a failure"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --assert --timescale 1ns/100ps -Wno-fatal -f sim.f \
		--top-module mem_bus_tb -Mdir obj_dir -o mem_bus_sim
	./obj_dir/mem_bus_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "Simulation ended without a pass report"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
